/* design/apf_io_pkg.sv */
package apf_io_pkg;

	// bridge bus
	localparam int bridge_addr_w = 32;
	localparam int bridge_data_w = 32;

	// pads and joystick words
	localparam int num_players = 2;
	localparam int joystick_w = 32;

	// rom size masks
	localparam int mask_w = 26;
	localparam int num_rom_regions = 3;
	localparam int rom_mask_width [num_rom_regions] = '{23, 19, 24};
	localparam int crom_fill_w = 16;
	localparam int num_crom_thresholds = 8;
	// sprite rom byte sizes, 256 KiB up to 32 MiB
	localparam logic [mask_w-1:0] crom_thresholds [num_crom_thresholds] = '{
		26'h004_0000, 26'h008_0000, 26'h010_0000, 26'h020_0000,
		26'h040_0000, 26'h080_0000, 26'h100_0000, 26'h200_0000
	};

	// address map
	localparam logic [bridge_addr_w-1:0] p2_base = 32'h1000_0000;
	localparam logic [bridge_addr_w-1:0] m_base = 32'h10F8_0000;
	localparam logic [bridge_addr_w-1:0] v1_base = 32'h2000_0000;
	localparam logic [bridge_addr_w-1:0] crom_base = 32'h4000_0000;
	localparam logic [bridge_addr_w-1:0] cfg_base = 32'hF000_0000;
	localparam logic [bridge_addr_w-1:0] rtc_base = 32'hF100_0000;

	// config field offsets from cfg_base
	localparam logic [bridge_addr_w-1:0] ofs_controller_map_1 = 32'h00;
	localparam logic [bridge_addr_w-1:0] ofs_controller_map_2 = 32'h04;
	localparam logic [bridge_addr_w-1:0] ofs_dipsw = 32'h08;
	localparam logic [bridge_addr_w-1:0] ofs_system_type = 32'h0C;
	localparam logic [bridge_addr_w-1:0] ofs_memory_card_enable = 32'h10;
	localparam logic [bridge_addr_w-1:0] ofs_use_mouse = 32'h14;
	localparam logic [bridge_addr_w-1:0] ofs_video_mode = 32'h18;
	localparam logic [bridge_addr_w-1:0] ofs_ch_enable = 32'h1C;
	localparam logic [bridge_addr_w-1:0] ofs_snd_enable = 32'h20;
	localparam logic [bridge_addr_w-1:0] ofs_cart_pchip_main = 32'h24;
	localparam logic [bridge_addr_w-1:0] ofs_use_pcm = 32'h28;
	localparam logic [bridge_addr_w-1:0] ofs_cart_pchip_sub = 32'h2C;
	localparam logic [bridge_addr_w-1:0] ofs_cmc_chip = 32'h30;
	localparam logic [bridge_addr_w-1:0] ofs_screen_x_pos = 32'h34;
	localparam logic [bridge_addr_w-1:0] ofs_screen_y_pos = 32'h38;
	localparam logic [bridge_addr_w-1:0] ofs_v2_offset = 32'h3C;
	localparam logic [bridge_addr_w-1:0] ofs_cart_chip = 32'h40;
	// rtc words, offsets from rtc_base
	localparam logic [bridge_addr_w-1:0] ofs_rtc_hi = 32'h00;
	localparam logic [bridge_addr_w-1:0] ofs_rtc_lo = 32'h04;

	// non-zero reset values
	localparam logic [7:0] dipsw_rst = 8'hFF;
	localparam logic [1:0] system_type_rst = 2'd1;
	localparam logic [5:0] ch_enable_rst = 6'h3F;
	localparam logic [3:0] snd_enable_rst = 4'hF;

	typedef enum logic [1:0] {
		region_p2 = 2'd0,
		region_m = 2'd1,
		region_v1 = 2'd2
	} rom_region_e;

	// codes outside the list fall back to standard
	typedef enum logic [3:0] {
		layout_standard = 4'd0,
		layout_neogeo = 4'd1,
		layout_neogeo_cd = 4'd2
	} pad_layout_e;

	typedef struct packed {
		logic rd;
		logic wr;
		logic [bridge_addr_w-1:0] addr;
		logic [bridge_data_w-1:0] wr_data;
	} bridge_req_t;

	typedef struct packed {
		logic [num_rom_regions-1:0] rom;
		logic crom;
		logic cfg;
		logic [bridge_addr_w-1:0] addr;
		logic [bridge_data_w-1:0] data;
	} region_wr_t;

	// bit 0 is up, bit 15 is start
	typedef struct packed {
		logic start;
		logic select;
		logic r3;
		logic l3;
		logic r2;
		logic l2;
		logic r1;
		logic l1;
		logic y;
		logic x;
		logic b;
		logic a;
		logic right;
		logic left;
		logic down;
		logic up;
	} pad_keys_t;

	typedef struct packed {
		logic [3:0] controller_map_1;
		logic [3:0] controller_map_2;
		logic [7:0] dipsw;
		logic [1:0] system_type;
		logic [1:0] memory_card_enable;
		logic [1:0] use_mouse;
		logic video_mode;
		logic [5:0] ch_enable;
		logic [3:0] snd_enable;
		logic cart_pchip_main;
		logic use_pcm;
		logic [2:0] cart_pchip_sub;
		logic [1:0] cmc_chip;
		logic [31:0] screen_x_pos;
		logic [31:0] screen_y_pos;
		logic [23:0] v2_offset;
		logic [1:0] cart_chip;
		logic [63:0] rtc;
	} core_config_t;

	localparam core_config_t cfg_reset = '{
		dipsw: dipsw_rst,
		system_type: system_type_rst,
		ch_enable: ch_enable_rst,
		snd_enable: snd_enable_rst,
		default: '0
	};

endpackage

/* design/bridge_write_decode.sv */
`timescale 1ns/1ps

module bridge_write_decode (
	input logic clk_74a,
	input logic reset_l_main,
	input apf_io_pkg::bridge_req_t bridge,
	output apf_io_pkg::region_wr_t wr
);
	import apf_io_pkg::*;

	logic [num_rom_regions-1:0] rom_d;
	logic crom_d;
	logic cfg_d;
	logic [num_rom_regions-1:0] rom_q;
	logic crom_q;
	logic cfg_q;
	logic [bridge_addr_w-1:0] addr_q;
	logic [bridge_data_w-1:0] data_q;

	// region map, one compare per region
	always_comb begin
		rom_d = '0;
		// p2 spans 1000_0000 to 107F_FFFF
		rom_d[region_p2] = bridge.wr && (bridge.addr[31:23] == p2_base[31:23]);
		// m spans 10F8_0000 to 10FF_FFFF
		rom_d[region_m] = bridge.wr && (bridge.addr[31:19] == m_base[31:19]);
		rom_d[region_v1] = bridge.wr && (bridge.addr[31:24] == v1_base[31:24]);
		crom_d = bridge.wr && (bridge.addr[31:28] == crom_base[31:28]);
		// exact field match happens in the register file
		cfg_d = bridge.wr && ((bridge.addr[31:24] == cfg_base[31:24]) ||
			(bridge.addr[31:24] == rtc_base[31:24]));
	end

	always_ff @(posedge clk_74a or negedge reset_l_main) begin
		if (!reset_l_main) begin
			rom_q <= '0;
			crom_q <= 1'b0;
			cfg_q <= 1'b0;
		end else begin
			rom_q <= rom_d;
			crom_q <= crom_d;
			cfg_q <= cfg_d;
		end
	end

	// payload only moves on a write
	always_ff @(posedge clk_74a) begin
		if (bridge.wr) begin
			addr_q <= bridge.addr;
			data_q <= bridge.wr_data;
		end
	end

	assign wr = '{
		rom: rom_q,
		crom: crom_q,
		cfg: cfg_q,
		addr: addr_q,
		data: data_q
	};

endmodule

/* design/rom_mask_tracker.sv */
`timescale 1ns/1ps

module rom_mask_tracker #(
	parameter int region_w = 24
) (
	input logic clk_74a,
	input logic reset_l_main,
	input logic wr_strobe,
	input logic [apf_io_pkg::bridge_addr_w-1:0] wr_addr,
	output logic [apf_io_pkg::mask_w-1:0] mask
);
	import apf_io_pkg::*;

	logic [region_w-1:0] fill;

	// highest set bit and everything below it
	always_comb begin
		logic seen;
		seen = 1'b0;
		for (int i = region_w - 1; i >= 0; i--) begin
			seen = seen | wr_addr[i];
			fill[i] = seen;
		end
	end

	// last write in the region wins
	always_ff @(posedge clk_74a or negedge reset_l_main) begin
		if (!reset_l_main) begin
			mask <= '0;
		end else if (wr_strobe) begin
			mask <= mask_w'(fill);
		end
	end

endmodule

/* design/crom_size_tracker.sv */
`timescale 1ns/1ps

module crom_size_tracker (
	input logic clk_74a,
	input logic reset_l_main,
	input logic wr_strobe,
	input logic [apf_io_pkg::bridge_addr_w-1:0] wr_addr,
	output logic [apf_io_pkg::mask_w-1:0] mask
);
	import apf_io_pkg::*;

	logic [mask_w-1:0] addr_q;
	logic [num_crom_thresholds-1:0] flags_q;

	// three stages: latch, compare, build mask
	always_ff @(posedge clk_74a or negedge reset_l_main) begin
		if (!reset_l_main) begin
			addr_q <= '0;
			flags_q <= '0;
			mask <= '0;
		end else begin
			if (wr_strobe) begin
				addr_q <= wr_addr[mask_w-1:0];
			end
			for (int i = 0; i < num_crom_thresholds; i++) begin
				flags_q[i] <= addr_q > crom_thresholds[i];
			end
			// flags land on bits 23:16 above a 64 KiB fill
			mask <= mask_w'({flags_q, {crom_fill_w{|flags_q}}});
		end
	end

endmodule

/* design/core_config_regs.sv */
`timescale 1ns/1ps

module core_config_regs (
	input logic clk_74a,
	input logic reset_l_main,
	input apf_io_pkg::region_wr_t wr,
	input apf_io_pkg::bridge_req_t bridge,
	output logic [apf_io_pkg::bridge_data_w-1:0] rd_data,
	input logic dataslot_allcomplete,
	input logic core_reset_n,
	input apf_io_pkg::pad_keys_t p1_keys,
	output apf_io_pkg::core_config_t cfg,
	output logic [3:0] cart_pchip,
	output logic start_system
);
	import apf_io_pkg::*;

	logic [bridge_data_w-1:0] rd_next;

	// option writes, data truncated to field width
	always_ff @(posedge clk_74a or negedge reset_l_main) begin
		if (!reset_l_main) begin
			cfg <= cfg_reset;
		end else if (wr.cfg) begin
			case (wr.addr)
				cfg_base + ofs_controller_map_1: cfg.controller_map_1 <= wr.data[3:0];
				cfg_base + ofs_controller_map_2: cfg.controller_map_2 <= wr.data[3:0];
				cfg_base + ofs_dipsw: cfg.dipsw <= wr.data[7:0];
				cfg_base + ofs_system_type: cfg.system_type <= wr.data[1:0];
				cfg_base + ofs_memory_card_enable: cfg.memory_card_enable <= wr.data[1:0];
				cfg_base + ofs_use_mouse: cfg.use_mouse <= wr.data[1:0];
				cfg_base + ofs_video_mode: cfg.video_mode <= wr.data[0];
				cfg_base + ofs_ch_enable: cfg.ch_enable <= wr.data[5:0];
				cfg_base + ofs_snd_enable: cfg.snd_enable <= wr.data[3:0];
				cfg_base + ofs_cart_pchip_main: cfg.cart_pchip_main <= wr.data[0];
				cfg_base + ofs_use_pcm: cfg.use_pcm <= wr.data[0];
				cfg_base + ofs_cart_pchip_sub: cfg.cart_pchip_sub <= wr.data[2:0];
				cfg_base + ofs_cmc_chip: cfg.cmc_chip <= wr.data[1:0];
				cfg_base + ofs_screen_x_pos: cfg.screen_x_pos <= wr.data;
				cfg_base + ofs_screen_y_pos: cfg.screen_y_pos <= wr.data;
				cfg_base + ofs_v2_offset: cfg.v2_offset <= wr.data[23:0];
				cfg_base + ofs_cart_chip: cfg.cart_chip <= wr.data[1:0];
				// rtc high word first
				rtc_base + ofs_rtc_hi: cfg.rtc[63:32] <= wr.data;
				rtc_base + ofs_rtc_lo: cfg.rtc[31:0] <= wr.data;
				default: ;
			endcase
		end
	end

	// readback select, zero outside the map
	always_comb begin
		case (bridge.addr)
			cfg_base + ofs_controller_map_1: rd_next = bridge_data_w'(cfg.controller_map_1);
			cfg_base + ofs_controller_map_2: rd_next = bridge_data_w'(cfg.controller_map_2);
			cfg_base + ofs_dipsw: rd_next = bridge_data_w'(cfg.dipsw);
			cfg_base + ofs_system_type: rd_next = bridge_data_w'(cfg.system_type);
			cfg_base + ofs_memory_card_enable: rd_next = bridge_data_w'(cfg.memory_card_enable);
			cfg_base + ofs_use_mouse: rd_next = bridge_data_w'(cfg.use_mouse);
			cfg_base + ofs_video_mode: rd_next = bridge_data_w'(cfg.video_mode);
			cfg_base + ofs_ch_enable: rd_next = bridge_data_w'(cfg.ch_enable);
			cfg_base + ofs_snd_enable: rd_next = bridge_data_w'(cfg.snd_enable);
			cfg_base + ofs_cart_pchip_main: rd_next = bridge_data_w'(cfg.cart_pchip_main);
			cfg_base + ofs_use_pcm: rd_next = bridge_data_w'(cfg.use_pcm);
			cfg_base + ofs_cart_pchip_sub: rd_next = bridge_data_w'(cfg.cart_pchip_sub);
			cfg_base + ofs_cmc_chip: rd_next = bridge_data_w'(cfg.cmc_chip);
			cfg_base + ofs_screen_x_pos: rd_next = cfg.screen_x_pos;
			cfg_base + ofs_screen_y_pos: rd_next = cfg.screen_y_pos;
			cfg_base + ofs_v2_offset: rd_next = bridge_data_w'(cfg.v2_offset);
			cfg_base + ofs_cart_chip: rd_next = bridge_data_w'(cfg.cart_chip);
			rtc_base + ofs_rtc_hi: rd_next = cfg.rtc[63:32];
			rtc_base + ofs_rtc_lo: rd_next = cfg.rtc[31:0];
			default: rd_next = '0;
		endcase
	end

	// held until the next rd pulse
	always_ff @(posedge clk_74a or negedge reset_l_main) begin
		if (!reset_l_main) begin
			rd_data <= '0;
		end else if (bridge.rd) begin
			rd_data <= rd_next;
		end
	end

	// protection chip select, main flag has priority
	always_ff @(posedge clk_74a or negedge reset_l_main) begin
		if (!reset_l_main) begin
			cart_pchip <= '0;
		end else if (cfg.cart_pchip_main) begin
			cart_pchip <= 4'd2;
		end else if (cfg.cart_pchip_sub inside {[3'd1:3'd5]}) begin
			cart_pchip <= {1'b0, cfg.cart_pchip_sub} + 4'd2;
		end else begin
			cart_pchip <= '0;
		end
	end

	// holding l1 on pad 1 keeps the core parked
	always_ff @(posedge clk_74a or negedge reset_l_main) begin
		if (!reset_l_main) begin
			start_system <= 1'b0;
		end else begin
			start_system <= dataslot_allcomplete && core_reset_n && !p1_keys.l1;
		end
	end

endmodule

/* design/pad_layout_map.sv */
`timescale 1ns/1ps

module pad_layout_map (
	input logic clk_74a,
	input logic reset_l_main,
	input apf_io_pkg::pad_layout_e layout,
	input apf_io_pkg::pad_keys_t keys,
	output logic [apf_io_pkg::joystick_w-1:0] joystick
);
	import apf_io_pkg::*;

	// neo geo buttons d c b a on bits 7 to 4
	logic [3:0] face;

	always_comb begin
		case (layout)
			layout_neogeo: face = {keys.a, keys.x, keys.b, keys.y};
			layout_neogeo_cd: face = {keys.x, keys.y, keys.a, keys.b};
			// standard, and unknown codes act as standard
			default: face = {keys.y, keys.x, keys.b, keys.a};
		endcase
	end

	always_ff @(posedge clk_74a or negedge reset_l_main) begin
		if (!reset_l_main) begin
			joystick <= '0;
		end else begin
			joystick <= joystick_w'({keys.select, keys.start, face,
				keys.up, keys.down, keys.left, keys.right});
		end
	end

endmodule

/* design/apf_io_top.sv */
`timescale 1ns/1ps

module apf_io_top (
	input logic clk_74a,
	input logic reset_l_main,
	input apf_io_pkg::bridge_req_t bridge,
	output logic [apf_io_pkg::bridge_data_w-1:0] bridge_rd_data,
	input apf_io_pkg::pad_keys_t pad_keys [apf_io_pkg::num_players],
	input logic dataslot_allcomplete,
	input logic core_reset_n,
	output logic [apf_io_pkg::joystick_w-1:0] joystick [apf_io_pkg::num_players],
	output logic [apf_io_pkg::mask_w-1:0] p2rom_mask,
	output logic [apf_io_pkg::mask_w-1:0] mrom_mask,
	output logic [apf_io_pkg::mask_w-1:0] v1rom_mask,
	output logic [apf_io_pkg::mask_w-1:0] crom_mask,
	output apf_io_pkg::core_config_t cfg,
	output logic [3:0] cart_pchip,
	output logic start_system
);
	import apf_io_pkg::*;

	region_wr_t wr;
	logic [mask_w-1:0] rom_mask [num_rom_regions];
	pad_layout_e layout [num_players];

	bridge_write_decode i_decode (
		.clk_74a(clk_74a),
		.reset_l_main(reset_l_main),
		.bridge(bridge),
		.wr(wr)
	);

	// one tracker per linear rom region
	for (genvar g = 0; g < num_rom_regions; g++) begin : g_rom
		rom_mask_tracker #(
			.region_w(rom_mask_width[g])
		) i_mask (
			.clk_74a(clk_74a),
			.reset_l_main(reset_l_main),
			.wr_strobe(wr.rom[g]),
			.wr_addr(wr.addr),
			.mask(rom_mask[g])
		);
	end

	assign p2rom_mask = rom_mask[region_p2];
	assign mrom_mask = rom_mask[region_m];
	assign v1rom_mask = rom_mask[region_v1];

	crom_size_tracker i_crom (
		.clk_74a(clk_74a),
		.reset_l_main(reset_l_main),
		.wr_strobe(wr.crom),
		.wr_addr(wr.addr),
		.mask(crom_mask)
	);

	core_config_regs i_cfg (
		.clk_74a(clk_74a),
		.reset_l_main(reset_l_main),
		.wr(wr),
		.bridge(bridge),
		.rd_data(bridge_rd_data),
		.dataslot_allcomplete(dataslot_allcomplete),
		.core_reset_n(core_reset_n),
		.p1_keys(pad_keys[0]),
		.cfg(cfg),
		.cart_pchip(cart_pchip),
		.start_system(start_system)
	);

	// layout codes come straight from the option registers
	assign layout[0] = pad_layout_e'(cfg.controller_map_1);
	assign layout[1] = pad_layout_e'(cfg.controller_map_2);

	for (genvar p = 0; p < num_players; p++) begin : g_pad
		pad_layout_map i_pad (
			.clk_74a(clk_74a),
			.reset_l_main(reset_l_main),
			.layout(layout[p]),
			.keys(pad_keys[p]),
			.joystick(joystick[p])
		);
	end

endmodule

/* test/apf_io_sva.sv */
`timescale 1ns/1ps

module apf_io_sva (
	input logic clk_74a,
	input logic reset_l_main,
	input apf_io_pkg::bridge_req_t bridge,
	input logic [apf_io_pkg::bridge_data_w-1:0] bridge_rd_data,
	input logic core_reset_n,
	input logic start_system,
	input logic [apf_io_pkg::mask_w-1:0] p2rom_mask,
	input logic [apf_io_pkg::mask_w-1:0] mrom_mask,
	input logic [apf_io_pkg::mask_w-1:0] v1rom_mask,
	input logic [apf_io_pkg::mask_w-1:0] crom_mask
);
	import apf_io_pkg::*;

	int failures = 0;

	// ones from bit 0 upward, or all zero
	property p_contiguous(m);
		@(posedge clk_74a) disable iff (!reset_l_main)
			(m & (m + 1'b1)) == '0;
	endproperty

	a_start_gated: assert property (@(posedge clk_74a) disable iff (!reset_l_main)
		!core_reset_n |=> !start_system)
		else begin
			failures++;
			$error("start_system high one cycle after core_reset_n low");
		end

	a_p2_mask: assert property (p_contiguous(p2rom_mask))
		else begin
			failures++;
			$error("p2rom_mask is not a contiguous fill");
		end
	a_m_mask: assert property (p_contiguous(mrom_mask))
		else begin
			failures++;
			$error("mrom_mask is not a contiguous fill");
		end
	a_v1_mask: assert property (p_contiguous(v1rom_mask))
		else begin
			failures++;
			$error("v1rom_mask is not a contiguous fill");
		end
	a_crom_mask: assert property (p_contiguous(crom_mask))
		else begin
			failures++;
			$error("crom_mask is not a contiguous fill");
		end

	// readback only moves right after a rd pulse
	a_rd_hold: assert property (@(posedge clk_74a) disable iff (!reset_l_main)
		$changed(bridge_rd_data) |-> $past(bridge.rd))
		else begin
			failures++;
			$error("bridge_rd_data changed without a rd pulse");
		end

endmodule

bind apf_io_top apf_io_sva i_sva (.*);

/* test/apf_io_tb.sv */
`timescale 1ns/1ps

module apf_io_tb;
	import apf_io_pkg::*;

	localparam int num_fields = 17;
	localparam int timeout_cycles = 2000;
	localparam logic [31:0] field_ofs [num_fields] = '{
		ofs_controller_map_1, ofs_controller_map_2, ofs_dipsw, ofs_system_type,
		ofs_memory_card_enable, ofs_use_mouse, ofs_video_mode, ofs_ch_enable,
		ofs_snd_enable, ofs_cart_pchip_main, ofs_use_pcm, ofs_cart_pchip_sub,
		ofs_cmc_chip, ofs_screen_x_pos, ofs_screen_y_pos, ofs_v2_offset, ofs_cart_chip
	};
	localparam int field_w [num_fields] = '{4, 4, 8, 2, 2, 2, 1, 6, 4, 1, 1, 3, 2, 32, 32, 24, 2};
	// dipsw, system_type, ch_enable and snd_enable come up non-zero
	localparam logic [31:0] field_rst [num_fields] = '{
		32'h0, 32'h0, 32'hFF, 32'h1, 32'h0, 32'h0, 32'h0, 32'h3F, 32'hF,
		32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0
	};
	localparam int region_w [3] = '{23, 19, 24};
	localparam logic [31:0] region_base [3] = '{32'h1000_0000, 32'h10F8_0000, 32'h2000_0000};

	logic clk_74a;
	logic reset_l_main;
	bridge_req_t bridge;
	logic [31:0] bridge_rd_data;
	pad_keys_t pad_keys [num_players];
	logic dataslot_allcomplete;
	logic core_reset_n;
	logic [31:0] joystick [num_players];
	logic [mask_w-1:0] p2rom_mask;
	logic [mask_w-1:0] mrom_mask;
	logic [mask_w-1:0] v1rom_mask;
	logic [mask_w-1:0] crom_mask;
	core_config_t cfg;
	logic [3:0] cart_pchip;
	logic start_system;
	logic [mask_w-1:0] rom_expect [3];
	integer seed;
	int errors;
	int cycle_count = 0;

	apf_io_top i_dut (
		.clk_74a(clk_74a),
		.reset_l_main(reset_l_main),
		.bridge(bridge),
		.bridge_rd_data(bridge_rd_data),
		.pad_keys(pad_keys),
		.dataslot_allcomplete(dataslot_allcomplete),
		.core_reset_n(core_reset_n),
		.joystick(joystick),
		.p2rom_mask(p2rom_mask),
		.mrom_mask(mrom_mask),
		.v1rom_mask(v1rom_mask),
		.crom_mask(crom_mask),
		.cfg(cfg),
		.cart_pchip(cart_pchip),
		.start_system(start_system)
	);

	initial begin
		clk_74a = 1'b0;
		forever #50 clk_74a = ~clk_74a;
	end

	always @(posedge clk_74a) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("run did not finish within %0d cycles", timeout_cycles);
			$display("TESTS FAILED");
			$finish;
		end
	end

	// inputs move 10 ns after the edge
	task automatic tick();
		@(posedge clk_74a);
		#10;
	endtask

	task automatic compare_value(input string test, input logic [63:0] exp,
		input logic [63:0] act);
		if (act !== exp) begin
			errors++;
			$display("MISMATCH %s expected %h actual %h", test, exp, act);
		end
	endtask

	// three settle cycles cover the c rom pipeline
	task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
		bridge.wr = 1'b1;
		bridge.addr = addr;
		bridge.wr_data = data;
		tick();
		bridge.wr = 1'b0;
		repeat (3) tick();
	endtask

	task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
		bridge.rd = 1'b1;
		bridge.addr = addr;
		tick();
		bridge.rd = 1'b0;
		data = bridge_rd_data;
	endtask

	function automatic logic [31:0] expected_joystick(input logic [3:0] code,
		input pad_keys_t k);
		logic [3:0] face;
		if (code == 4'd1) begin
			face = {k.a, k.x, k.b, k.y};
		end else if (code == 4'd2) begin
			face = {k.x, k.y, k.a, k.b};
		end else begin
			face = {k.y, k.x, k.b, k.a};
		end
		return {22'd0, k.select, k.start, face, k.up, k.down, k.left, k.right};
	endfunction

	function automatic logic [mask_w-1:0] prefix_fill(input logic [31:0] ofs, input int w);
		logic [mask_w-1:0] m;
		m = '0;
		for (int i = 0; i < w; i++) begin
			if (ofs[i]) begin
				m = (mask_w'(1) << (i + 1)) - 1'b1;
			end
		end
		return m;
	endfunction

	task automatic reset_state_test();
		core_config_t want;
		want = '0;
		want.dipsw = 8'hFF;
		want.system_type = 2'd1;
		want.ch_enable = 6'h3F;
		want.snd_enable = 4'hF;
		if (cfg !== want) begin
			errors++;
			$display("MISMATCH reset_cfg expected %h actual %h", want, cfg);
		end
		compare_value("reset_rd_data", 0, bridge_rd_data);
		compare_value("reset_p2_mask", 0, p2rom_mask);
		compare_value("reset_m_mask", 0, mrom_mask);
		compare_value("reset_v1_mask", 0, v1rom_mask);
		compare_value("reset_crom_mask", 0, crom_mask);
		compare_value("reset_joystick_1", 0, joystick[0]);
		compare_value("reset_joystick_2", 0, joystick[1]);
		compare_value("reset_cart_pchip", 0, cart_pchip);
		compare_value("reset_start_system", 0, start_system);
	endtask

	task automatic config_readback_test();
		logic [31:0] data;
		logic [31:0] got;
		logic [63:0] keep;
		logic [31:0] rtc_word [2];
		for (int i = 0; i < num_fields; i++) begin
			bus_read(cfg_base + field_ofs[i], got);
			compare_value("cfg_reset", field_rst[i], got);
		end
		for (int i = 0; i < num_fields; i++) begin
			data = $random(seed);
			keep = (64'd1 << field_w[i]) - 1;
			bus_write(cfg_base + field_ofs[i], data);
			bus_read(cfg_base + field_ofs[i], got);
			compare_value("cfg_write", data & keep[31:0], got);
		end
		for (int i = 0; i < 2; i++) begin
			rtc_word[i] = $random(seed);
			bus_write(rtc_base + 4 * i, rtc_word[i]);
			bus_read(rtc_base + 4 * i, got);
			compare_value("rtc_write", rtc_word[i], got);
		end
		// high word at rtc_base, low word at rtc_base + 4
		compare_value("rtc_cfg", {rtc_word[0], rtc_word[1]}, cfg.rtc);
		bus_read(cfg_base + 32'h44, got);
		compare_value("cfg_unmapped", 0, got);
	endtask

	task automatic pad_layout_test();
		logic [3:0] codes [4];
		codes = '{4'd0, 4'd1, 4'd2, 4'd9};
		foreach (codes[c]) begin
			bus_write(cfg_base + ofs_controller_map_1, codes[c]);
			bus_write(cfg_base + ofs_controller_map_2, codes[(c + 1) % 4]);
			for (int k = 0; k < 16; k++) begin
				pad_keys[0] = pad_keys_t'(16'd1 << k);
				pad_keys[1] = pad_keys_t'(16'd1 << ((k + 7) % 16));
				tick();
				compare_value("pad_layout_p1", expected_joystick(codes[c], pad_keys[0]),
					joystick[0]);
				compare_value("pad_layout_p2",
					expected_joystick(codes[(c + 1) % 4], pad_keys[1]), joystick[1]);
			end
		end
		pad_keys[0] = '0;
		pad_keys[1] = '0;
	endtask

	task automatic check_rom_masks(input string test);
		compare_value(test, rom_expect[0], p2rom_mask);
		compare_value(test, rom_expect[1], mrom_mask);
		compare_value(test, rom_expect[2], v1rom_mask);
	endtask

	task automatic rom_mask_test();
		logic [31:0] ofs [4];
		rom_expect = '{'0, '0, '0};
		check_rom_masks("rom_mask_reset");
		for (int r = 0; r < 3; r++) begin
			ofs = '{32'h1, 32'h123, 32'h2_0001, (32'd1 << region_w[r]) - 1};
			foreach (ofs[j]) begin
				bus_write(region_base[r] + ofs[j], $random(seed));
				rom_expect[r] = prefix_fill(ofs[j], region_w[r]);
				check_rom_masks("rom_mask_write");
			end
		end
		// a lower address written last shrinks the mask again
		for (int r = 0; r < 3; r++) begin
			bus_write(region_base[r] + 32'h123, $random(seed));
			rom_expect[r] = prefix_fill(32'h123, region_w[r]);
			check_rom_masks("rom_mask_last");
		end
		// gaps around the m region and an unused top byte
		bus_write(32'h1080_0000, 32'h0);
		bus_write(32'h10F7_FFFF, 32'h0);
		bus_write(32'h3000_0000, 32'h0);
		check_rom_masks("rom_mask_outside");
	endtask

	task automatic crom_mask_test();
		logic [31:0] a;
		logic [7:0] flags;
		logic [mask_w-1:0] want;
		for (int t = 0; t < 8; t++) begin
			for (int d = -1; d <= 1; d++) begin
				a = (32'h4_0000 << t) + d;
				for (int i = 0; i < 8; i++) begin
					flags[i] = a > (32'h4_0000 << i);
				end
				want = {2'b00, flags, {16{|flags}}};
				bus_write(32'h4000_0000 + a, $random(seed));
				compare_value("crom_mask", want, crom_mask);
			end
		end
	endtask

	task automatic pchip_start_test();
		logic [3:0] want;
		logic [2:0] bits;
		for (int m = 0; m < 2; m++) begin
			bus_write(cfg_base + ofs_cart_pchip_main, m);
			for (int s = 0; s < 8; s++) begin
				bus_write(cfg_base + ofs_cart_pchip_sub, s);
				if (m == 1) begin
					want = 4'd2;
				end else if (s >= 1 && s <= 5) begin
					want = 4'(s + 2);
				end else begin
					want = 4'd0;
				end
				compare_value("cart_pchip", want, cart_pchip);
			end
		end
		for (int c = 0; c < 8; c++) begin
			bits = 3'(c);
			dataslot_allcomplete = bits[0];
			core_reset_n = bits[1];
			pad_keys[0] = '0;
			pad_keys[0].l1 = bits[2];
			tick();
			compare_value("start_system", bits[0] && bits[1] && !bits[2], start_system);
		end
	endtask

	initial begin
		seed = 51012;
		errors = 0;
		reset_l_main = 1'b0;
		bridge = '0;
		pad_keys[0] = '0;
		pad_keys[1] = '0;
		dataslot_allcomplete = 1'b0;
		core_reset_n = 1'b0;
		repeat (4) @(posedge clk_74a);
		#10;
		reset_l_main = 1'b1;
		reset_state_test();
		config_readback_test();
		pad_layout_test();
		rom_mask_test();
		crom_mask_test();
		pchip_start_test();
		$display("errors: %0d, assertion failures: %0d", errors, i_dut.i_sva.failures);
		if (errors == 0 && i_dut.i_sva.failures == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

/* src.f */
design/apf_io_pkg.sv
design/bridge_write_decode.sv
design/rom_mask_tracker.sv
design/crom_size_tracker.sv
design/core_config_regs.sv
design/pad_layout_map.sv
design/apf_io_top.sv
test/apf_io_sva.sv
test/apf_io_tb.sv

/* Bender.yml */
package:
  name: apf_io

sources:
  - design/apf_io_pkg.sv
  - design/bridge_write_decode.sv
  - design/rom_mask_tracker.sv
  - design/crom_size_tracker.sv
  - design/core_config_regs.sv
  - design/pad_layout_map.sv
  - design/apf_io_top.sv
  - target: test
    files:
      - test/apf_io_sva.sv
      - test/apf_io_tb.sv
